//--- rtl/jesd_rx_pkg.sv
// Shared sizes, register map and lane types for the JESD204 receive link layer.
// All RTL blocks reference these by scoped names.

`default_nettype none

package jesd_rx_pkg;

  // ******************************
  // Link sizes
  // ******************************
  localparam int NUM_LANES       = 4;
  localparam int OCTETS_PER_BEAT = 4;
  localparam int LANE_DATA_W     = 8 * OCTETS_PER_BEAT;
  localparam int BUF_DEPTH       = 64;  // 256-octet multiframe
  localparam int BUF_ADDR_W      = 6;
  localparam int LMFC_CNT_W      = 8;

  // ******************************
  // APB register map
  // ******************************
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] REG_CTRL             = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_OCTETS_PER_FRAME = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_OCTETS_PER_MF    = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_LMFC_OFFSET      = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_BUFFER_DELAY     = 8'h10;
  localparam logic [APB_ADDR_W-1:0] REG_LANES_DISABLE    = 8'h14;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS           = 8'h18;

  // Configuration after reset
  localparam logic [7:0] RST_OCTETS_PER_FRAME = 8'd4;
  localparam logic [9:0] RST_OCTETS_PER_MF    = 10'd128;
  localparam logic [7:0] RST_LMFC_OFFSET      = 8'd0;
  localparam logic [7:0] RST_BUFFER_DELAY     = 8'd0;
  localparam logic [3:0] RST_LANES_DISABLE    = 4'b0000;

  // ******************************
  // Lane types
  // ******************************
  typedef logic [LANE_DATA_W-1:0]     lane_data_t;
  typedef logic [NUM_LANES-1:0]       lane_mask_t;
  typedef logic [OCTETS_PER_BEAT-1:0] octet_mask_t;
  typedef logic [LMFC_CNT_W-1:0]      lmfc_cnt_t;

endpackage

`default_nettype wire

//--- rtl/jesd_rx_apb_regs.sv
// APB slave holding the link configuration and the alignment status.
// Zero wait states; unmapped addresses answer with pslverr.
// Configuration fields feed the LMFC, release and frame marker blocks.

`default_nettype none

module jesd_rx_apb_regs (
  input  wire logic                                    clk,
  input  wire logic                                    device_reset,
  input  wire logic                                    i_psel,
  input  wire logic                                    i_penable,
  input  wire logic                                    i_pwrite,
  input  wire logic [jesd_rx_pkg::APB_ADDR_W-1:0]      i_paddr,
  input  wire logic [jesd_rx_pkg::APB_DATA_W-1:0]      i_pwdata,
  output logic      [jesd_rx_pkg::APB_DATA_W-1:0]      o_prdata,
  output logic                                         o_pready,
  output logic                                         o_pslverr,
  input  wire logic                                    i_released,
  input  wire logic                                    i_sysref_alignment_error,
  output logic                                         o_early_release,
  output logic      [7:0]                              o_octets_per_frame,
  output logic      [9:0]                              o_octets_per_mf,
  output logic      [7:0]                              o_lmfc_offset,
  output logic      [7:0]                              o_buffer_delay,
  output jesd_rx_pkg::lane_mask_t                      o_lanes_disable
);

  logic access;
  logic wr_en;
  logic mapped;
  logic align_err_sticky;

  assign access   = i_psel & i_penable;
  assign wr_en    = access & i_pwrite;
  assign o_pready = 1'b1;  // No wait states

  // ******************************
  // Register writes
  // ******************************
  always_ff @(posedge clk) begin
    if (device_reset) begin
      o_early_release    <= 1'b0;
      o_octets_per_frame <= jesd_rx_pkg::RST_OCTETS_PER_FRAME;
      o_octets_per_mf    <= jesd_rx_pkg::RST_OCTETS_PER_MF;
      o_lmfc_offset      <= jesd_rx_pkg::RST_LMFC_OFFSET;
      o_buffer_delay     <= jesd_rx_pkg::RST_BUFFER_DELAY;
      o_lanes_disable    <= jesd_rx_pkg::RST_LANES_DISABLE;
    end else if (wr_en) begin
      case (i_paddr)
        jesd_rx_pkg::REG_CTRL:             o_early_release    <= i_pwdata[0];
        jesd_rx_pkg::REG_OCTETS_PER_FRAME: o_octets_per_frame <= i_pwdata[7:0];
        jesd_rx_pkg::REG_OCTETS_PER_MF:    o_octets_per_mf    <= i_pwdata[9:0];
        jesd_rx_pkg::REG_LMFC_OFFSET:      o_lmfc_offset      <= i_pwdata[7:0];
        jesd_rx_pkg::REG_BUFFER_DELAY:     o_buffer_delay     <= i_pwdata[7:0];
        jesd_rx_pkg::REG_LANES_DISABLE:    o_lanes_disable    <= i_pwdata[3:0];
        default: ;
      endcase
    end
  end

  // Sticky error, a new error wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (device_reset) begin
      align_err_sticky <= 1'b0;
    end else if (i_sysref_alignment_error) begin
      align_err_sticky <= 1'b1;
    end else if (wr_en && i_paddr == jesd_rx_pkg::REG_STATUS && i_pwdata[1]) begin
      align_err_sticky <= 1'b0;
    end
  end

  // ******************************
  // Read mux and decode
  // ******************************
  always_comb begin
    o_prdata = '0;
    mapped   = 1'b1;
    case (i_paddr)
      jesd_rx_pkg::REG_CTRL:             o_prdata[0]   = o_early_release;
      jesd_rx_pkg::REG_OCTETS_PER_FRAME: o_prdata[7:0] = o_octets_per_frame;
      jesd_rx_pkg::REG_OCTETS_PER_MF:    o_prdata[9:0] = o_octets_per_mf;
      jesd_rx_pkg::REG_LMFC_OFFSET:      o_prdata[7:0] = o_lmfc_offset;
      jesd_rx_pkg::REG_BUFFER_DELAY:     o_prdata[7:0] = o_buffer_delay;
      jesd_rx_pkg::REG_LANES_DISABLE:    o_prdata[3:0] = o_lanes_disable;
      jesd_rx_pkg::REG_STATUS:           o_prdata[1:0] = {align_err_sticky, i_released};
      default:                           mapped        = 1'b0;
    endcase
  end

  assign o_pslverr = access & ~mapped;

endmodule

`default_nettype wire

//--- rtl/jesd_rx_lmfc.sv
// Local multiframe clock counter, aligned to the external sysref.
// The first sysref edge after reset aligns; later edges are checked
// against the running phase and flag a one-cycle alignment error.

`default_nettype none

module jesd_rx_lmfc (
  input  wire logic                  clk,
  input  wire logic                  device_reset,
  input  wire logic                  i_sysref,
  input  wire logic [9:0]            i_octets_per_mf,
  input  wire logic [7:0]            i_lmfc_offset,
  output jesd_rx_pkg::lmfc_cnt_t     o_lmfc_counter,
  output logic                       o_lmfc_edge,
  output logic                       o_sysref_alignment_error
);

  jesd_rx_pkg::lmfc_cnt_t beats_per_mf;
  jesd_rx_pkg::lmfc_cnt_t cnt_adv;
  logic                   sysref_d;
  logic                   sysref_edge;
  logic                   aligned;

  assign beats_per_mf = i_octets_per_mf[9:2];  // Four octets per beat
  assign cnt_adv      = (o_lmfc_counter == beats_per_mf - 1'b1) ? '0 : o_lmfc_counter + 1'b1;
  assign sysref_edge  = i_sysref & ~sysref_d;

  always_ff @(posedge clk) begin
    if (device_reset) begin
      sysref_d <= 1'b0;
    end else begin
      sysref_d <= i_sysref;
    end
  end

  // ******************************
  // Counter and alignment check
  // ******************************
  always_ff @(posedge clk) begin
    if (device_reset) begin
      o_lmfc_counter           <= '0;
      aligned                  <= 1'b0;
      o_sysref_alignment_error <= 1'b0;
    end else begin
      o_sysref_alignment_error <= 1'b0;
      if (sysref_edge) begin
        o_lmfc_counter <= i_lmfc_offset;
        aligned        <= 1'b1;
        // Phase drift only counts once we were aligned
        if (aligned && cnt_adv != i_lmfc_offset) begin
          o_sysref_alignment_error <= 1'b1;
        end
      end else begin
        o_lmfc_counter <= cnt_adv;
      end
    end
  end

  assign o_lmfc_edge = (o_lmfc_counter == '0);

endmodule

`default_nettype wire

//--- rtl/jesd_rx_lane_buffer.sv
// Per-lane elastic buffer for lane-to-lane deskew.
// Writes start at address 0 with the lane's first valid beat; reads start
// at address 0 once the common release is high, with a registered output.

`default_nettype none

module jesd_rx_lane_buffer (
  input  wire logic                    clk,
  input  wire logic                    device_reset,
  input  wire jesd_rx_pkg::lane_data_t i_data,
  input  wire logic                    i_valid,
  input  wire logic                    i_release,
  output logic                         o_ready,
  output jesd_rx_pkg::lane_data_t      o_data
);

  jesd_rx_pkg::lane_data_t          mem [jesd_rx_pkg::BUF_DEPTH];
  logic [jesd_rx_pkg::BUF_ADDR_W-1:0] wr_ptr;
  logic [jesd_rx_pkg::BUF_ADDR_W-1:0] rd_ptr;

  // ******************************
  // Write side
  // ******************************
  always_ff @(posedge clk) begin
    if (device_reset) begin
      wr_ptr  <= '0;
      o_ready <= 1'b0;
    end else if (i_valid) begin
      wr_ptr  <= wr_ptr + 1'b1;  // Wraps at BUF_DEPTH
      o_ready <= 1'b1;           // Holds at least one beat
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // ******************************
  // Read side
  // ******************************
  always_ff @(posedge clk) begin
    if (device_reset) begin
      rd_ptr <= '0;
    end else if (i_release) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_release) begin
      o_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

//--- rtl/jesd_rx_release_ctrl.sv
// Common buffer release for all enabled lanes.
// A release opportunity is registered at the configured LMFC position, or
// every cycle on early release; rx valid follows the release by one cycle.

`default_nettype none

module jesd_rx_release_ctrl (
  input  wire logic                    clk,
  input  wire logic                    device_reset,
  input  wire jesd_rx_pkg::lmfc_cnt_t  i_lmfc_counter,
  input  wire logic [7:0]              i_buffer_delay,
  input  wire logic                    i_early_release,
  input  wire jesd_rx_pkg::lane_mask_t i_lane_ready,
  input  wire jesd_rx_pkg::lane_mask_t i_lanes_disable,
  output logic                         o_release,
  output logic                         o_rx_valid
);

  logic release_opportunity;
  logic all_ready;

  // Disabled lanes never block the release
  assign all_ready = &(i_lane_ready | i_lanes_disable);

  always_ff @(posedge clk) begin
    if (device_reset) begin
      release_opportunity <= 1'b0;
      o_release           <= 1'b0;
      o_rx_valid          <= 1'b0;
    end else begin
      release_opportunity <= (i_lmfc_counter == i_buffer_delay) | i_early_release;
      if (release_opportunity && all_ready) begin
        o_release <= 1'b1;  // Sticky until reset
      end
      o_rx_valid <= o_release;  // Matches the registered buffer read
    end
  end

endmodule

`default_nettype wire

//--- rtl/jesd_rx_frame_mark.sv
// Frame and multiframe start/end markers for the released data.
// Octet positions are held at zero until rx valid and then advance by
// four per beat; each octet gets its own marker bit.

`default_nettype none

module jesd_rx_frame_mark (
  input  wire logic              clk,
  input  wire logic              device_reset,
  input  wire logic              i_rx_valid,
  input  wire logic [7:0]        i_octets_per_frame,
  input  wire logic [9:0]        i_octets_per_mf,
  output jesd_rx_pkg::octet_mask_t o_sof,
  output jesd_rx_pkg::octet_mask_t o_eof,
  output jesd_rx_pkg::octet_mask_t o_somf,
  output jesd_rx_pkg::octet_mask_t o_eomf
);

  logic [7:0] frame_pos;
  logic [9:0] mf_pos;
  logic [7:0] frame_pos_nxt;
  logic [9:0] mf_pos_nxt;

  // ******************************
  // Per-octet position walk
  // ******************************
  always_comb begin
    logic [7:0] fp;
    logic [9:0] mp;
    fp = frame_pos;
    mp = mf_pos;
    for (int j = 0; j < jesd_rx_pkg::OCTETS_PER_BEAT; j++) begin
      o_sof[j]  = i_rx_valid & (fp == '0);
      o_eof[j]  = i_rx_valid & (fp == i_octets_per_frame - 1'b1);
      o_somf[j] = i_rx_valid & (mp == '0);
      o_eomf[j] = i_rx_valid & (mp == i_octets_per_mf - 1'b1);
      // Wrap each octet so F below four still works
      fp = (fp == i_octets_per_frame - 1'b1) ? '0 : fp + 1'b1;
      mp = (mp == i_octets_per_mf - 1'b1) ? '0 : mp + 1'b1;
    end
    frame_pos_nxt = fp;
    mf_pos_nxt    = mp;
  end

  // Held at octet 0 while no data flows
  always_ff @(posedge clk) begin
    if (device_reset || !i_rx_valid) begin
      frame_pos <= '0;
      mf_pos    <= '0;
    end else begin
      frame_pos <= frame_pos_nxt;
      mf_pos    <= mf_pos_nxt;
    end
  end

endmodule

`default_nettype wire

//--- rtl/jesd_rx_top.sv
// Top level of the JESD204 receive link layer.
// Connects the APB registers, the LMFC, the release controller, the frame
// markers and one elastic buffer per lane.

`default_nettype none

module jesd_rx_top (
  input  wire logic                                          clk,
  input  wire logic                                          device_reset,
  // APB slave
  input  wire logic                                          i_psel,
  input  wire logic                                          i_penable,
  input  wire logic                                          i_pwrite,
  input  wire logic [jesd_rx_pkg::APB_ADDR_W-1:0]            i_paddr,
  input  wire logic [jesd_rx_pkg::APB_DATA_W-1:0]            i_pwdata,
  output logic      [jesd_rx_pkg::APB_DATA_W-1:0]            o_prdata,
  output logic                                               o_pready,
  output logic                                               o_pslverr,
  input  wire logic                                          i_sysref,
  // Lanes in
  input  wire jesd_rx_pkg::lane_data_t [jesd_rx_pkg::NUM_LANES-1:0] i_lane_data,
  input  wire jesd_rx_pkg::lane_mask_t                       i_lane_valid,
  // Released data out
  output jesd_rx_pkg::lane_data_t [jesd_rx_pkg::NUM_LANES-1:0] o_rx_data,
  output logic                                               o_rx_valid,
  output jesd_rx_pkg::octet_mask_t                           o_sof,
  output jesd_rx_pkg::octet_mask_t                           o_eof,
  output jesd_rx_pkg::octet_mask_t                           o_somf,
  output jesd_rx_pkg::octet_mask_t                           o_eomf,
  output logic                                               o_lmfc_edge,
  output logic                                               o_sysref_alignment_error
);

  logic                   early_release;
  logic [7:0]             octets_per_frame;
  logic [9:0]             octets_per_mf;
  logic [7:0]             lmfc_offset;
  logic [7:0]             buffer_delay;
  jesd_rx_pkg::lane_mask_t lanes_disable;
  jesd_rx_pkg::lmfc_cnt_t lmfc_counter;
  jesd_rx_pkg::lane_mask_t lane_ready;
  logic                   buffer_release;

  jesd_rx_apb_regs u_apb_regs (
    .clk                      (clk),
    .device_reset             (device_reset),
    .i_psel                   (i_psel),
    .i_penable                (i_penable),
    .i_pwrite                 (i_pwrite),
    .i_paddr                  (i_paddr),
    .i_pwdata                 (i_pwdata),
    .o_prdata                 (o_prdata),
    .o_pready                 (o_pready),
    .o_pslverr                (o_pslverr),
    .i_released               (buffer_release),
    .i_sysref_alignment_error (o_sysref_alignment_error),
    .o_early_release          (early_release),
    .o_octets_per_frame       (octets_per_frame),
    .o_octets_per_mf          (octets_per_mf),
    .o_lmfc_offset            (lmfc_offset),
    .o_buffer_delay           (buffer_delay),
    .o_lanes_disable          (lanes_disable)
  );

  jesd_rx_lmfc u_lmfc (
    .clk                      (clk),
    .device_reset             (device_reset),
    .i_sysref                 (i_sysref),
    .i_octets_per_mf          (octets_per_mf),
    .i_lmfc_offset            (lmfc_offset),
    .o_lmfc_counter           (lmfc_counter),
    .o_lmfc_edge              (o_lmfc_edge),
    .o_sysref_alignment_error (o_sysref_alignment_error)
  );

  jesd_rx_release_ctrl u_release_ctrl (
    .clk             (clk),
    .device_reset    (device_reset),
    .i_lmfc_counter  (lmfc_counter),
    .i_buffer_delay  (buffer_delay),
    .i_early_release (early_release),
    .i_lane_ready    (lane_ready),
    .i_lanes_disable (lanes_disable),
    .o_release       (buffer_release),
    .o_rx_valid      (o_rx_valid)
  );

  jesd_rx_frame_mark u_frame_mark (
    .clk                (clk),
    .device_reset       (device_reset),
    .i_rx_valid         (o_rx_valid),
    .i_octets_per_frame (octets_per_frame),
    .i_octets_per_mf    (octets_per_mf),
    .o_sof              (o_sof),
    .o_eof              (o_eof),
    .o_somf             (o_somf),
    .o_eomf             (o_eomf)
  );

  // ******************************
  // One elastic buffer per lane
  // ******************************
  for (genvar i = 0; i < jesd_rx_pkg::NUM_LANES; i++) begin : gen_lane
    jesd_rx_lane_buffer u_lane_buffer (
      .clk          (clk),
      .device_reset (device_reset),
      .i_data       (i_lane_data[i]),
      .i_valid      (i_lane_valid[i]),
      .i_release    (buffer_release),
      .o_ready      (lane_ready[i]),
      .o_data       (o_rx_data[i])
    );
  end

endmodule

`default_nettype wire

//--- bench/jesd_rx_chk.sv
// Concurrent assertions bound into the receive link top level.
// Watches rx valid after release, idle markers and APB error timing.

`default_nettype none

module jesd_rx_chk (
  input wire logic       clk,
  input wire logic       device_reset,
  input wire logic       i_rx_valid,
  input wire logic [3:0] i_sof,
  input wire logic       i_psel,
  input wire logic       i_penable,
  input wire logic       i_pslverr
);
  timeunit 1ns;
  timeprecision 100ps;

  // Released lanes stay released until reset
  a_valid_holds: assert property (@(posedge clk) disable iff (device_reset)
    $past(i_rx_valid) |-> i_rx_valid)
    else $error("rx valid fell after the release");

  a_sof_idle: assert property (@(posedge clk) disable iff (device_reset)
    !i_rx_valid |-> (i_sof == 4'b0000))
    else $error("frame start marked without valid data");

  a_pslverr_access: assert property (@(posedge clk)
    i_pslverr |-> (i_psel && i_penable))  // Error only in the access phase
    else $error("pslverr outside an APB access phase");

endmodule

`default_nettype wire

//--- bench/jesd_rx_tb.sv
// Testbench for the JESD204 receive link layer.
// Drives APB, sysref and four lanes of random beats, then checks the released
// data against per-lane queues and the markers against the octet index rule.

`default_nettype none

module jesd_rx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LANE_RUN = 380;
  localparam int MARK_RUN = 120;
  localparam int TEST_CYC = 2 * LANE_RUN + 80 + 32 + 6 * MARK_RUN + 10 * 40 + 200;
  localparam logic [7:0]  CFG_ADDR [6] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14};
  localparam logic [31:0] CFG_MASK [6] = '{32'h1, 32'hFF, 32'h3FF, 32'hFF, 32'hFF, 32'hF};

  logic            clk = 1'b0;
  logic            device_reset;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [7:0]      paddr;
  logic [31:0]     pwdata;
  logic [31:0]     prdata;
  logic            pready;
  logic            pslverr;
  logic            sysref;
  logic [3:0][31:0] lane_data;
  logic [3:0]      lane_valid;
  logic [3:0][31:0] rx_data;
  logic            rx_valid;
  logic [3:0]      sof;
  logic [3:0]      eof;
  logic [3:0]      somf;
  logic [3:0]      eomf;
  logic            lmfc_edge;
  logic            align_err;

  logic [31:0] lane_q [4][$];  // Beats written, per lane
  int          start_cyc [4];
  logic [3:0]  lane_on;
  int          seed;
  int          errors;
  int          checks;
  int          tests;
  int          test_base;

  jesd_rx_top u_jesd_rx_top (
    .clk (clk), .device_reset (device_reset),
    .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite), .i_paddr (paddr),
    .i_pwdata (pwdata), .o_prdata (prdata), .o_pready (pready), .o_pslverr (pslverr),
    .i_sysref (sysref), .i_lane_data (lane_data), .i_lane_valid (lane_valid),
    .o_rx_data (rx_data), .o_rx_valid (rx_valid),
    .o_sof (sof), .o_eof (eof), .o_somf (somf), .o_eomf (eomf),
    .o_lmfc_edge (lmfc_edge), .o_sysref_alignment_error (align_err)
  );

  bind jesd_rx_top jesd_rx_chk u_chk (
    .clk (clk), .device_reset (device_reset), .i_rx_valid (o_rx_valid), .i_sof (o_sof),
    .i_psel (i_psel), .i_penable (i_penable), .i_pslverr (o_pslverr)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  initial begin
    #(TEST_CYC * 10);
    $display("watchdog expired after %0d cycles, the run hung", TEST_CYC);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %0s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0s finished with %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  task automatic do_reset();
    device_reset = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    sysref       = 1'b0;
    lane_valid   = '0;
    lane_data    = '0;
    for (int n = 0; n < 4; n++) lane_q[n].delete();
    repeat (16) @(negedge clk);
    device_reset = 1'b0;
  endtask

  // ******************************
  // APB and sysref drivers
  // ******************************
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;  // Access phase, write lands at the next edge
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(negedge clk);
    penable = 1'b1;
    #2;
    data = prdata;
    err  = pslverr;
    check("apb pready", 1, pready);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Rising edge lands gap cycles after the previous one
  task automatic sysref_pulse(input int gap, output logic err);
    repeat (gap - 1) @(negedge clk);
    sysref = 1'b1;
    @(negedge clk);
    sysref = 1'b0;
    err    = align_err;
  endtask

  task automatic set_skew(input int max_skew);
    for (int n = 0; n < 4; n++) start_cyc[n] = $unsigned($random(seed)) % (max_skew + 1);
  endtask

  // ******************************
  // Lane driver and model
  // ******************************
  task automatic run_lanes(input string name, input int cycles, input int f, input int mf,
                           output int first_valid, output int beats);
    int         k;
    logic       seen;
    logic [3:0] e_sof;
    logic [3:0] e_eof;
    logic [3:0] e_somf;
    logic [3:0] e_eomf;
    k           = 0;
    seen        = 1'b0;
    first_valid = -1;
    beats       = 0;
    for (int c = 0; c < cycles; c++) begin
      if (seen) check({name, " valid hold"}, 1, rx_valid);
      if (!rx_valid) begin
        check({name, " idle sof"}, 0, sof);
      end else begin
        if (!seen) first_valid = c;
        seen = 1'b1;
        for (int n = 0; n < 4; n++) begin
          if (lane_on[n] && lane_q[n].size() == 0) begin
            errors++;
            $display("%0s: lane %0d released a beat that was never written", name, n);
          end else if (lane_on[n]) begin
            check($sformatf("%0s lane %0d data", name, n), lane_q[n].pop_front(), rx_data[n]);
          end
        end
        for (int j = 0; j < 4; j++) begin
          e_sof[j]  = ((k + j) % f) == 0;
          e_eof[j]  = ((k + j) % f) == f - 1;
          e_somf[j] = ((k + j) % mf) == 0;
          e_eomf[j] = ((k + j) % mf) == mf - 1;
        end
        check({name, " markers"}, {e_eomf, e_somf, e_eof, e_sof}, {eomf, somf, eof, sof});
        k += 4;
        beats++;
      end
      for (int n = 0; n < 4; n++) begin
        lane_valid[n] = lane_on[n] && c >= start_cyc[n];
        lane_data[n]  = $random(seed);
        if (lane_valid[n]) lane_q[n].push_back(lane_data[n]);
      end
      @(negedge clk);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] val;
    logic        err;
    int          fv;
    int          beats;
    int          d;
    seed      = 32'hcea6_c295;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    test_base = 0;
    lane_on   = '0;
    set_skew(0);
    do_reset();

    for (int i = 0; i < 6; i++) begin
      val = $random(seed);
      apb_write(CFG_ADDR[i], val);
      apb_read(CFG_ADDR[i], rd, err);
      check($sformatf("regs 0x%02h", CFG_ADDR[i]), val & CFG_MASK[i], rd);
      check("regs mapped pslverr", 0, err);
    end
    apb_read(8'h1C, rd, err);
    check("regs unmapped pslverr", 1, err);
    end_test("apb_regs");

    do_reset();
    lane_on = 4'b1111;
    set_skew(20);
    run_lanes("deskew", LANE_RUN, 4, 128, fv, beats);
    check("deskew beats", 1, beats >= 300);
    end_test("deskew");

    do_reset();
    d = $unsigned($random(seed)) % 32;  // 32 beats per multiframe
    apb_write(8'h10, d);
    set_skew(0);
    while (!lmfc_edge) @(negedge clk);
    // One full multiframe, edge only at its first beat
    for (int c = 0; c < 32; c++) begin
      check("release lmfc edge", c == 0, lmfc_edge);
      @(negedge clk);
    end
    run_lanes("release", 80, 4, 128, fv, beats);
    check("release first valid", d + 3, fv);
    end_test("release_timing");

    for (int fi = 0; fi < 3; fi++) begin
      for (int mi = 0; mi < 2; mi++) begin
        do_reset();
        apb_write(8'h04, 1 << fi);
        apb_write(8'h08, 32 << mi);
        apb_write(8'h00, 1);  // Early release
        run_lanes($sformatf("marks F%0d MF%0d", 1 << fi, 32 << mi), MARK_RUN,
                  1 << fi, 32 << mi, fv, beats);
        check("marks release", 1, beats > 0);
      end
    end
    end_test("frame_marks");

    do_reset();
    lane_on = '0;
    sysref_pulse(1, err);
    check("sysref align", 0, err);
    sysref_pulse(32, err);
    check("sysref in phase", 0, err);
    sysref_pulse(35, err);
    check("sysref shifted", 1, err);
    apb_read(8'h18, rd, err);
    check("sysref sticky", 32'h2, rd);
    apb_write(8'h18, 32'h2);
    apb_read(8'h18, rd, err);
    check("sysref sticky clear", 32'h0, rd);
    end_test("sysref");

    do_reset();
    apb_write(8'h14, 32'h4);
    lane_on = 4'b1011;
    set_skew(20);
    run_lanes("disabled lane", LANE_RUN, 4, 128, fv, beats);
    check("disabled lane release", 1, beats > 0);
    end_test("disabled_lane");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- jesd_rx_top.f
rtl/jesd_rx_pkg.sv
rtl/jesd_rx_apb_regs.sv
rtl/jesd_rx_lmfc.sv
rtl/jesd_rx_lane_buffer.sv
rtl/jesd_rx_release_ctrl.sv
rtl/jesd_rx_frame_mark.sv
rtl/jesd_rx_top.sv
bench/jesd_rx_chk.sv
bench/jesd_rx_tb.sv

//--- Makefile
# Verilator flow for the JESD204 receive link layer

VERILATOR  ?= verilator
FILELIST   := jesd_rx_top.f
TOP        := jesd_rx_tb
RTL_TOP    := jesd_rx_top
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
